// ==== booth_multiplier.f ====
source/booth_pkg.sv
source/booth_ctrl_if.sv
source/booth_controller.sv
source/booth_datapath.sv
source/booth_multiplier.sv
verif/tb_booth_multiplier.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Booth multiplier testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_booth_multiplier
BUILD_DIR=obj_dir
LOG=sim.log

echo "Compiling with Verilator"
verilator --binary --timing --assert \
    -f booth_multiplier.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Compile failed with status $status"
    exit 1
fi

echo "Running simulation"
"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

// ==== verif/tb_booth_multiplier.sv ====
module tb_booth_multiplier;

    localparam int WIDTH        = 8;        // Operand width under test
    localparam int RESET_CYCLES = 5;        // Reset held low this long
    localparam int N_RANDOM     = 200;      // Random operand pairs
    localparam int N_CORNER     = 6;        // Edge-value pairs
    localparam int N_LATENCY    = 4;        // Strobe timing runs
    localparam int N_IGNORE     = 4;        // Runs with starts while busy
    localparam int N_CHAIN      = 4;        // Back-to-back runs
    localparam int N_RESET      = 2;        // Aborted run plus recovery run
    localparam int N_OPS        = N_RANDOM + N_CORNER + N_LATENCY + N_IGNORE
                                  + N_CHAIN + N_RESET;
    localparam int TIMEOUT_CYCLES = N_OPS * (WIDTH + 2) + RESET_CYCLES + 100;

    logic                      clk = 1'b0;  // Free-running clock
    logic                      rst_n;
    logic                      start;
    logic signed [WIDTH-1:0]   multiplicand;
    logic signed [WIDTH-1:0]   multiplier;
    logic signed [2*WIDTH-1:0] product;
    logic                      busy;
    logic                      done;

    integer seed;                           // State for $random
    int     err_count;                      // Errors over the whole run
    int     err_mark;                       // Error count at start of a test
    int     test_num;                       // Tests reported so far
    int     test_pass;
    int     test_fail;
    int     cycle_count = 0;                // Watchdog

    booth_multiplier #(
        .WIDTH (WIDTH)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .busy         (busy),
        .done         (done)
    );

    always #4 clk = ~clk;                   // Period 8

    // Stops a run that never reaches its end
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // Reference product of the sign-extended operands
    function automatic logic signed [2*WIDTH-1:0] model_product(
        input logic signed [WIDTH-1:0] a,
        input logic signed [WIDTH-1:0] b
    );
        logic signed [2*WIDTH-1:0] ea;
        logic signed [2*WIDTH-1:0] eb;
        ea = {{WIDTH{a[WIDTH-1]}}, a};
        eb = {{WIDTH{b[WIDTH-1]}}, b};
        return ea * eb;
    endfunction

    // Pulses start with the operands and returns after the sampling edge
    task automatic launch(input logic signed [WIDTH-1:0] a, input logic signed [WIDTH-1:0] b);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        @(negedge clk);
        if (done) begin                     // Previous done must be gone by now
            $display("ERR %0t: done high for more than one cycle", $time);
            err_count++;
        end
        @(posedge clk);                     // Edge 0
        start        <= 1'b0;
        multiplicand <= WIDTH'($random(seed));  // Junk that must not reach the result
        multiplier   <= WIDTH'($random(seed));
    endtask

    // Mode 1 chains a start into the done cycle and mode 2 pokes start while busy
    task automatic wait_done(
        input  int                      mode,
        input  logic signed [WIDTH-1:0] na,
        input  logic signed [WIDTH-1:0] nb,
        output bit                      got
    );
        int lat;
        lat = 0;
        got = 1'b0;
        @(negedge clk);
        if (!busy) begin
            $display("ERR %0t: busy low in the cycle after start was sampled", $time);
            err_count++;
        end
        if (done) begin
            $display("ERR %0t: done high one cycle after start was sampled", $time);
            err_count++;
        end
        while (!got && lat < WIDTH + 4) begin
            @(posedge clk);
            lat++;
            if (mode == 1 && lat == WIDTH) begin
                start        <= 1'b1;       // Sampled on the edge where done is high
                multiplicand <= na;
                multiplier   <= nb;
            end else if (mode == 2 && (lat == 2 || lat == WIDTH - 1)) begin
                start        <= 1'b1;       // Must be dropped
                multiplicand <= WIDTH'($random(seed));
                multiplier   <= WIDTH'($random(seed));
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (done) begin
                got = 1'b1;
                if (lat != WIDTH) begin
                    $display("ERR %0t: done after %0d cycles, expected %0d", $time, lat, WIDTH);
                    err_count++;
                end
                if (busy) begin
                    $display("ERR %0t: busy still high with done", $time);
                    err_count++;
                end
            end else if (!busy) begin
                $display("ERR %0t: busy dropped %0d cycles after start", $time, lat);
                err_count++;
            end
        end
        if (!got) begin
            $display("No done pulse arrived within %0d cycles of a start", WIDTH + 4);
            err_count++;
        end
    endtask

    task automatic check_product(input logic signed [WIDTH-1:0] a,
                                 input logic signed [WIDTH-1:0] b);
        logic signed [2*WIDTH-1:0] expected;
        expected = model_product(a, b);
        if (product !== expected) begin
            $display("ERR %0t: %0d * %0d expected %0d got %0d", $time, a, b, expected, product);
            err_count++;
        end
    endtask

    // One complete operation with its result check
    task automatic run_op(input logic signed [WIDTH-1:0] a, input logic signed [WIDTH-1:0] b);
        bit got;
        launch(a, b);
        wait_done(0, '0, '0, got);
        if (got) begin
            check_product(a, b);
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (err_count == err_mark) begin
            test_pass++;
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            test_fail++;
            $display("Test %0d %s: %0d errors", test_num, name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    initial begin
        logic signed [WIDTH-1:0] a;
        logic signed [WIDTH-1:0] b;
        logic signed [WIDTH-1:0] max_neg;
        logic signed [WIDTH-1:0] max_pos;
        logic signed [WIDTH-1:0] ca [N_CHAIN];
        logic signed [WIDTH-1:0] cb [N_CHAIN];
        logic signed [2*WIDTH-1:0] held;
        bit got;

        seed      = 72;
        err_count = 0;
        err_mark  = 0;
        test_num  = 0;
        test_pass = 0;
        test_fail = 0;
        max_neg   = {1'b1, {(WIDTH-1){1'b0}}};
        max_pos   = ~max_neg;
        rst_n        <= 1'b0;
        start        <= 1'b0;
        multiplicand <= '0;
        multiplier   <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < N_RANDOM; i++) begin
            a = WIDTH'($random(seed));
            b = WIDTH'($random(seed));
            run_op(a, b);
        end
        report_test("random products");

        run_op('0, WIDTH'($random(seed)));  // Zero times anything
        run_op(WIDTH'($random(seed)), '0);
        run_op(-1, -1);
        run_op(max_neg, max_neg);           // Most negative M needs the guard bit
        run_op(max_neg, max_pos);
        run_op(1, -1);
        report_test("corner operands");

        // Latency and busy are checked inside every wait
        for (int i = 0; i < N_LATENCY; i++) begin
            run_op(WIDTH'($random(seed)), WIDTH'($random(seed)));
        end
        report_test("latency and strobes");

        for (int i = 0; i < N_IGNORE; i++) begin
            a = WIDTH'($random(seed));
            b = WIDTH'($random(seed));
            launch(a, b);
            wait_done(2, '0, '0, got);
            if (got) begin
                check_product(a, b);        // First operands only
            end
            repeat (WIDTH) begin
                @(negedge clk);
                if (done || busy) begin
                    $display("ERR %0t: extra done or busy after ignored start", $time);
                    err_count++;
                end
            end
        end
        report_test("start while busy ignored");

        for (int i = 0; i < N_CHAIN; i++) begin
            ca[i] = WIDTH'($random(seed));
            cb[i] = WIDTH'($random(seed));
        end
        launch(ca[0], cb[0]);
        for (int i = 0; i < N_CHAIN - 1; i++) begin
            wait_done(1, ca[i+1], cb[i+1], got);
            if (got) begin
                check_product(ca[i], cb[i]);
            end
            @(posedge clk);                 // Next operation's edge 0
            start        <= 1'b0;
            multiplicand <= WIDTH'($random(seed));
            multiplier   <= WIDTH'($random(seed));
        end
        wait_done(0, '0, '0, got);
        if (got) begin
            check_product(ca[N_CHAIN-1], cb[N_CHAIN-1]);
        end
        held = product;
        repeat (10) begin
            @(negedge clk);
            if (product !== held || done) begin
                $display("ERR %0t: product %0d changed from %0d while idle", $time, product, held);
                err_count++;
            end
        end
        report_test("back-to-back and hold");

        launch(WIDTH'($random(seed)), WIDTH'($random(seed)));
        repeat (3) @(posedge clk);          // Somewhere in RUN
        rst_n <= 1'b0;
        @(negedge clk);
        if (busy || done || product !== '0) begin
            $display("ERR %0t: busy %0b done %0b product %0d after reset", $time, busy, done,
                     product);
            err_count++;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        run_op(WIDTH'($random(seed)), WIDTH'($random(seed)));
        report_test("reset mid-operation");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", test_num, test_pass,
                 test_fail, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== source/booth_multiplier.sv ====
module booth_multiplier #(
    parameter int WIDTH = 8                 // Operand width
) (
    input  logic                      clk,           // Clock
    input  logic                      rst_n,         // Async reset, active low
    input  logic                      start,         // Start strobe
    input  logic signed [WIDTH-1:0]   multiplicand,  // Sampled with start
    input  logic signed [WIDTH-1:0]   multiplier,    // Sampled with start
    output logic signed [2*WIDTH-1:0] product,       // Signed result
    output logic                      busy,          // Operation in progress
    output logic                      done           // Result valid pulse
);

    // Control and status between the FSM and the datapath
    booth_ctrl_if #(
        .WIDTH (WIDTH)
    ) ctl_if (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // IDLE/RUN sequencer
    booth_controller i_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .busy  (busy),
        .ctl   (ctl_if.ctrl)
    );

    // Registers, add/sub, shift, counter
    booth_datapath #(
        .WIDTH (WIDTH)
    ) i_dp (
        .clk          (clk),
        .rst_n        (rst_n),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .done         (done),
        .dp           (ctl_if.dp)
    );

endmodule

// ==== source/booth_datapath.sv ====
module booth_datapath
    import booth_pkg::*;
#(
    parameter int WIDTH = 8                 // Operand width
) (
    input  logic                      clk,           // Clock
    input  logic                      rst_n,         // Async reset, active low
    input  logic signed [WIDTH-1:0]   multiplicand,  // Taken into M on load
    input  logic signed [WIDTH-1:0]   multiplier,    // Taken into Q on load
    output logic signed [2*WIDTH-1:0] product,       // Held until the next done
    output logic                      done,          // One-cycle pulse
    booth_ctrl_if.dp                  dp             // Strobes in, status out
);

    localparam int CW = $clog2(WIDTH) + 1;  // Counter has to hold WIDTH itself

    // A and M carry a guard bit so A minus M cannot wrap for M most negative
    logic signed [WIDTH:0]     a_reg;       // Accumulator
    logic signed [WIDTH:0]     m_reg;       // Multiplicand, sign extended
    logic        [WIDTH-1:0]   q_reg;       // Multiplier, low product half
    logic                      q_1_reg;     // Bit below Q
    logic        [CW-1:0]      cnt;         // Steps left
    logic signed [WIDTH:0]     a_op;        // A after add or subtract
    logic signed [2*WIDTH+1:0] shift_in;    // {A, Q, Q_1} before shift
    logic signed [2*WIDTH+1:0] shift_out;   // Arithmetic right shift by one

    // Add or subtract M per recoded pair
    always_comb begin
        case (dp.op)
            BOOTH_ADD: a_op = a_reg + m_reg;
            BOOTH_SUB: a_op = a_reg - m_reg;
            default:   a_op = a_reg;        // Shift only
        endcase
    end

    assign shift_in  = {a_op, q_reg, q_1_reg};
    assign shift_out = shift_in >>> 1;      // Sign of A is replicated

    // Operand and partial product registers
    always_ff @(posedge clk) begin
        if (dp.load) begin
            a_reg   <= '0;                  // Fresh accumulator
            m_reg   <= {multiplicand[WIDTH-1], multiplicand};
            q_reg   <= multiplier;
            q_1_reg <= 1'b0;                // Implied zero below LSB
        end else if (dp.iterate) begin
            a_reg   <= shift_out[2*WIDTH+1:WIDTH+1];
            q_reg   <= shift_out[WIDTH:1];
            q_1_reg <= shift_out[0];        // Old q0
        end
    end

    // Iteration counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (dp.load) begin
            cnt <= CW'(WIDTH);              // One step per multiplier bit
        end else if (dp.iterate) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign dp.count_done = (cnt == CW'(1)); // Current step is the last
    assign dp.q0         = q_reg[0];
    assign dp.q_1        = q_1_reg;

    // Result register and done strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
            done    <= 1'b0;
        end else begin
            done <= dp.finish;              // Visible the cycle after last step
            if (dp.finish) begin
                product <= shift_out[2*WIDTH:1];  // Low 2W bits of {A, Q}
            end
        end
    end

    // Counter stays in range
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt <= CW'(WIDTH));

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

// ==== source/booth_controller.sv ====
module booth_controller
    import booth_pkg::*;
(
    input  logic        clk,                // Clock
    input  logic        rst_n,              // Async reset, active low
    input  logic        start,              // Start strobe, sampled in IDLE only
    output logic        busy,               // High while stepping
    booth_ctrl_if.ctrl  ctl                 // Control to datapath, status back
);

    booth_state_t state;                    // Current state
    booth_state_t next_state;               // State for next edge
    booth_op_t    step_op;                  // Recoded operation this cycle

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;                  // Come up idle
        end else begin
            state <= next_state;            // Advance
        end
    end

    // Recoding from the live datapath bits
    assign step_op = booth_decode(ctl.q0, ctl.q_1);

    // Next state and strobes
    always_comb begin
        case (state)
            IDLE: begin
                if (start) begin
                    next_state  = RUN;      // Operands taken this edge
                    ctl.load    = 1'b1;     // Capture M and Q
                    ctl.iterate = 1'b0;     // No step yet
                    ctl.op      = BOOTH_NOP;
                    ctl.finish  = 1'b0;
                end else begin
                    next_state  = IDLE;     // Keep waiting
                    ctl.load    = 1'b0;
                    ctl.iterate = 1'b0;
                    ctl.op      = BOOTH_NOP;
                    ctl.finish  = 1'b0;
                end
            end
            RUN: begin
                if (ctl.count_done) begin
                    next_state  = IDLE;     // Last step done at this edge
                    ctl.load    = 1'b0;     // Start is ignored in RUN
                    ctl.iterate = 1'b1;     // Final step
                    ctl.op      = step_op;
                    ctl.finish  = 1'b1;     // Product written, done next cycle
                end else begin
                    next_state  = RUN;      // More steps to go
                    ctl.load    = 1'b0;
                    ctl.iterate = 1'b1;     // Step every RUN cycle
                    ctl.op      = step_op;  // Add, sub or shift only
                    ctl.finish  = 1'b0;
                end
            end
            default: begin
                next_state  = IDLE;         // Recover from a bad encoding
                ctl.load    = 1'b0;
                ctl.iterate = 1'b0;
                ctl.op      = BOOTH_NOP;
                ctl.finish  = 1'b0;
            end
        endcase
    end

    assign busy = (state == RUN);           // Registered state, no glitches

    // No datapath step outside RUN
    a_no_iter_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> !ctl.iterate);

    // Finish only on the step the counter marks as last
    a_finish_last: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.finish |-> ctl.count_done);

    // A start during RUN must not reload the operands
    a_no_load_run: assert property (@(posedge clk) disable iff (!rst_n)
        (state == RUN) |-> !ctl.load);

endmodule

// ==== source/booth_ctrl_if.sv ====
interface booth_ctrl_if
    import booth_pkg::*;
#(
    parameter int WIDTH = 8                 // Operand width, sets the iteration count
) (
    input logic clk,                        // Clock for the checks below
    input logic rst_n                       // Active-low reset
);

    logic      load;                        // Capture operands, preset counter
    logic      iterate;                     // One Booth step this cycle
    booth_op_t op;                          // Add, subtract or shift only
    logic      finish;                      // Last step, write product
    logic      q0;                          // Q register LSB
    logic      q_1;                         // Extra bit below Q
    logic      count_done;                  // Counter at one, last step

    modport ctrl (
        output load, iterate, op, finish,
        input  q0, q_1, count_done
    );

    modport dp (
        input  load, iterate, op, finish,
        output q0, q_1, count_done
    );

    // A load is followed by exactly WIDTH steps, finish only on the last one
    a_step_count: assert property (@(posedge clk) disable iff (!rst_n)
        load |=> (iterate && !finish) [*WIDTH-1] ##1 (iterate && finish) ##1 !iterate);

endinterface

// ==== source/booth_pkg.sv ====
package booth_pkg;

    // Controller state
    typedef enum logic {
        IDLE = 1'b0,                        // Waiting for start
        RUN  = 1'b1                         // One Booth step per clock
    } booth_state_t;

    // Operation applied to the accumulator in one iteration
    typedef enum logic [1:0] {
        BOOTH_NOP = 2'b00,                  // Pair 00 or 11, shift only
        BOOTH_SUB = 2'b01,                  // Pair 10, A minus M
        BOOTH_ADD = 2'b10                   // Pair 01, A plus M
    } booth_op_t;

    // Radix-2 recoding of the q0, q_1 pair
    function automatic booth_op_t booth_decode(
        input logic q0,                     // Multiplier LSB
        input logic q_1                     // Bit shifted out last step
    );
        case ({q0, q_1})
            2'b10:   return BOOTH_SUB;      // Start of a run of ones
            2'b01:   return BOOTH_ADD;      // End of a run of ones
            default: return BOOTH_NOP;      // Inside a run
        endcase
    endfunction

endpackage
